/* common/cakegame_config.svh */
`ifndef CAKEGAME_CONFIG_SVH
`define CAKEGAME_CONFIG_SVH

`define CAKE_PLAY_W   4
`define CAKE_DEPTH    16
`define CAKE_ADDR_W   4
`define CAKE_TIME_W   16
`define CAKE_POINTS_W 5

// word addresses on the cpu port
`define CAKE_REG_CTRL     5'd0
`define CAKE_REG_LEN      5'd1
`define CAKE_REG_SHOW     5'd2
`define CAKE_REG_TOUT     5'd3
`define CAKE_REG_STATUS   5'd4
`define CAKE_REG_MEM_BASE 5'd16

`endif

/* common/cakegame_pkg.sv */
`default_nettype none

`include "cakegame_config.svh"

package cakegame_pkg;

    typedef logic [`CAKE_PLAY_W-1:0]   play_t;
    typedef logic [`CAKE_ADDR_W-1:0]   seq_addr_t;
    typedef logic [`CAKE_ADDR_W:0]     seq_len_t;   // 1 up to depth
    typedef logic [`CAKE_TIME_W-1:0]   time_t;
    typedef logic [`CAKE_POINTS_W-1:0] points_t;

    typedef enum logic [3:0] {
        idle          = 4'h0,
        preparation   = 4'h1,
        show_play     = 4'h2,
        show_interval = 4'h3,
        next_show     = 4'h4,
        initiate_play = 4'h5,
        wait_play     = 4'h6,
        register_play = 4'h7,
        compare_play  = 4'h8,
        next_play     = 4'h9,
        end_state     = 4'hF
    } ctl_state_t;

    typedef enum logic [1:0] {
        blank = 2'b00,
        show  = 2'b01,
        echo  = 2'b10
    } out_sel_t;

    typedef struct packed {
        logic     clear_reg;
        logic     enable_reg;
        logic     clear_mem_counter;
        logic     enable_mem_counter;
        logic     clear_show_counter;
        logic     enable_show_counter;
        logic     enable_timeout_counter;
        logic     clear_points_counter;
        logic     enable_points_counter;
        out_sel_t out_sel;
    } ctl_t;

    typedef struct packed {
        logic end_mem_counter;
        logic correct_play;
        logic has_play;
        logic half_show;
        logic end_show;
        logic timeout;
    } dp_status_t;

    typedef struct packed {
        seq_len_t seq_len;
        time_t    show_time;
        time_t    timeout_limit;
    } cfg_t;

    typedef struct packed {
        logic      valid;
        seq_addr_t address;
        play_t     play;
    } mem_wr_t;

endpackage

`default_nettype wire

/* common/cakegame_bus_pkg.sv */
`default_nettype none

package cakegame_bus_pkg;

    typedef logic [4:0]  wb_adr_t;   // word address
    typedef logic [15:0] wb_dat_t;

    // master side, held until ack
    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t dat_w;
    } wb_req_t;

    typedef struct packed {
        logic    ack;
        wb_dat_t dat_r;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* rtl/cakegame_uc.sv */
`timescale 1ns/1ps
`default_nettype none

module cakegame_uc (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire logic                     start,
    input  wire cakegame_pkg::dp_status_t status,
    output cakegame_pkg::ctl_t            ctl,
    output logic                          finished,
    output cakegame_pkg::ctl_state_t      state
);

    cakegame_pkg::ctl_state_t state_q;
    cakegame_pkg::ctl_state_t state_d;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state_q <= cakegame_pkg::idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            cakegame_pkg::idle, cakegame_pkg::end_state: begin
                if (start) begin
                    state_d = cakegame_pkg::preparation;
                end
            end
            cakegame_pkg::preparation:   state_d = cakegame_pkg::show_play;
            cakegame_pkg::show_play: begin
                if (status.half_show) begin
                    state_d = cakegame_pkg::show_interval;
                end
            end
            cakegame_pkg::show_interval: begin
                if (status.end_show) begin
                    state_d = cakegame_pkg::next_show;
                end
            end
            cakegame_pkg::next_show: begin
                state_d = status.end_mem_counter ? cakegame_pkg::initiate_play
                                                 : cakegame_pkg::show_play;
            end
            cakegame_pkg::initiate_play: state_d = cakegame_pkg::wait_play;
            cakegame_pkg::wait_play: begin
                if (status.has_play) begin
                    state_d = cakegame_pkg::register_play;
                end else if (status.timeout) begin
                    state_d = cakegame_pkg::end_state;   // player gave up
                end
            end
            cakegame_pkg::register_play: state_d = cakegame_pkg::compare_play;
            cakegame_pkg::compare_play:  state_d = cakegame_pkg::next_play;
            cakegame_pkg::next_play: begin
                state_d = status.end_mem_counter ? cakegame_pkg::end_state
                                                 : cakegame_pkg::wait_play;
            end
            default:                     state_d = cakegame_pkg::idle;
        endcase
    end

    // commands decoded from the current state
    always_comb begin
        ctl = '0;
        ctl.out_sel = cakegame_pkg::blank;
        case (state_q)
            cakegame_pkg::preparation: begin
                ctl.clear_reg            = 1'b1;
                ctl.clear_mem_counter    = 1'b1;
                ctl.clear_show_counter   = 1'b1;
                ctl.clear_points_counter = 1'b1;
            end
            cakegame_pkg::show_play: begin
                ctl.enable_show_counter = 1'b1;
                ctl.out_sel             = cakegame_pkg::show;
            end
            cakegame_pkg::show_interval: ctl.enable_show_counter = 1'b1;
            cakegame_pkg::next_show:     ctl.enable_mem_counter  = 1'b1;
            cakegame_pkg::initiate_play: ctl.clear_mem_counter   = 1'b1;   // rewind for play
            cakegame_pkg::wait_play: begin
                ctl.enable_timeout_counter = 1'b1;
                ctl.out_sel                = cakegame_pkg::echo;
            end
            cakegame_pkg::register_play: begin
                ctl.enable_reg = 1'b1;
                ctl.out_sel    = cakegame_pkg::echo;
            end
            cakegame_pkg::compare_play:  ctl.out_sel = cakegame_pkg::echo;
            cakegame_pkg::next_play: begin
                ctl.enable_mem_counter    = 1'b1;
                ctl.enable_points_counter = status.correct_play;
                ctl.out_sel               = cakegame_pkg::echo;
            end
            default: begin
            end
        endcase
    end

    assign finished = (state_q == cakegame_pkg::end_state);
    assign state    = state_q;

endmodule

`default_nettype wire

/* rtl/cakegame_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cakegame_config.svh"

module cakegame_regs (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire cakegame_bus_pkg::wb_req_t wb_req,
    output cakegame_bus_pkg::wb_rsp_t      wb_rsp,
    output cakegame_pkg::cfg_t             cfg,
    output cakegame_pkg::mem_wr_t          mem_wr,
    output logic                           start,
    input  wire cakegame_pkg::ctl_state_t  state,
    input  wire logic                      finished,
    input  wire cakegame_pkg::points_t     points
);

    logic                      ack;
    logic                      access;
    logic                      wr_access;
    logic                      mem_sel;
    cakegame_pkg::seq_len_t    seq_len;
    cakegame_pkg::time_t       show_time;
    cakegame_pkg::time_t       timeout_limit;
    cakegame_bus_pkg::wb_dat_t rd_data;
    cakegame_bus_pkg::wb_dat_t dat_r;
    logic                      mem_valid;
    cakegame_pkg::seq_addr_t   mem_addr;
    cakegame_pkg::play_t       mem_play;

    assign access    = wb_req.cyc & wb_req.stb & ~ack;   // one wait cycle per access
    assign wr_access = access & wb_req.we;
    assign mem_sel   = (wb_req.adr >= `CAKE_REG_MEM_BASE);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ack           <= 1'b0;
            start         <= 1'b0;
            mem_valid     <= 1'b0;
            seq_len       <= 5'd4;
            show_time     <= 16'd8;
            timeout_limit <= 16'd200;
        end else begin
            ack       <= access;
            start     <= wr_access && (wb_req.adr == `CAKE_REG_CTRL) && wb_req.dat_w[0];
            mem_valid <= wr_access && mem_sel;
            if (wr_access) begin
                case (wb_req.adr)
                    `CAKE_REG_LEN:  seq_len       <= cakegame_pkg::seq_len_t'(wb_req.dat_w);
                    `CAKE_REG_SHOW: show_time     <= wb_req.dat_w;
                    `CAKE_REG_TOUT: timeout_limit <= wb_req.dat_w;
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (access) begin
            dat_r <= rd_data;
        end
        if (wr_access) begin
            mem_addr <= cakegame_pkg::seq_addr_t'(wb_req.adr - `CAKE_REG_MEM_BASE);
            mem_play <= cakegame_pkg::play_t'(wb_req.dat_w);
        end
    end

    always_comb begin
        rd_data = '0;
        case (wb_req.adr)
            `CAKE_REG_LEN:  rd_data = cakegame_bus_pkg::wb_dat_t'(seq_len);
            `CAKE_REG_SHOW: rd_data = show_time;
            `CAKE_REG_TOUT: rd_data = timeout_limit;
            `CAKE_REG_STATUS: begin
                rd_data[`CAKE_POINTS_W-1:0] = points;
                rd_data[11:8]               = state;
                rd_data[15]                 = finished;
            end
            default: begin
            end
        endcase
    end

    assign wb_rsp.ack        = ack;
    assign wb_rsp.dat_r      = dat_r;
    assign cfg.seq_len       = seq_len;
    assign cfg.show_time     = show_time;
    assign cfg.timeout_limit = timeout_limit;
    assign mem_wr.valid      = mem_valid;
    assign mem_wr.address    = mem_addr;
    assign mem_wr.play       = mem_play;

endmodule

`default_nettype wire

/* datapath/cakegame_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cakegame_config.svh"

module cakegame_datapath (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire cakegame_pkg::ctl_t    ctl,
    input  wire cakegame_pkg::cfg_t    cfg,
    input  wire cakegame_pkg::mem_wr_t mem_wr,
    input  wire cakegame_pkg::play_t   buttons,
    output cakegame_pkg::dp_status_t   status,
    output cakegame_pkg::points_t      points,
    output cakegame_pkg::play_t        leds
);

    cakegame_pkg::play_t     seq_mem [`CAKE_DEPTH];
    cakegame_pkg::seq_addr_t addr;
    cakegame_pkg::play_t     cur_play;
    cakegame_pkg::time_t     show_cnt;
    cakegame_pkg::time_t     tout_cnt;
    cakegame_pkg::play_t     buttons_q;
    cakegame_pkg::play_t     press_q;
    cakegame_pkg::play_t     play_reg;
    logic                    rise;
    logic                    has_play_q;
    logic                    end_mem;
    logic                    half_show;
    logic                    end_show;

    always_ff @(posedge clock) begin
        if (mem_wr.valid) begin
            seq_mem[mem_wr.address] <= mem_wr.play;
        end
    end

    assign cur_play = seq_mem[addr];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            addr <= '0;
        end else if (ctl.clear_mem_counter) begin
            addr <= '0;
        end else if (ctl.enable_mem_counter) begin
            addr <= addr + 1'b1;
        end
    end

    assign end_mem = ({1'b0, addr} == cfg.seq_len - 1'b1);

    // wraps at end of period so every play gets a full show
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            show_cnt <= '0;
        end else if (ctl.clear_show_counter) begin
            show_cnt <= '0;
        end else if (ctl.enable_show_counter) begin
            show_cnt <= end_show ? '0 : show_cnt + 1'b1;
        end
    end

    assign half_show = (show_cnt == (cfg.show_time >> 1));
    assign end_show  = (show_cnt == cfg.show_time - 1'b1);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            tout_cnt <= '0;
        end else if (!ctl.enable_timeout_counter) begin
            tout_cnt <= '0;
        end else begin
            tout_cnt <= tout_cnt + 1'b1;
        end
    end

    assign rise = |(buttons & ~buttons_q);   // any button going down

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            buttons_q  <= '0;
            has_play_q <= 1'b0;
        end else begin
            buttons_q  <= buttons;
            has_play_q <= rise;
        end
    end

    always_ff @(posedge clock) begin
        if (rise) begin
            press_q <= buttons;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            play_reg <= '0;
            points   <= '0;
            leds     <= '0;
        end else begin
            if (ctl.clear_reg) begin
                play_reg <= '0;
            end else if (ctl.enable_reg) begin
                play_reg <= press_q;
            end
            if (ctl.clear_points_counter) begin
                points <= '0;
            end else if (ctl.enable_points_counter) begin
                points <= points + 1'b1;
            end
            case (ctl.out_sel)
                cakegame_pkg::show: leds <= cur_play;
                cakegame_pkg::echo: leds <= play_reg;
                default:            leds <= '0;
            endcase
        end
    end

    assign status = '{
        end_mem_counter: end_mem,
        correct_play:    (play_reg == cur_play),
        has_play:        has_play_q,
        half_show:       half_show,
        end_show:        end_show,
        timeout:         (tout_cnt == cfg.timeout_limit)
    };

endmodule

`default_nettype wire

/* rtl/cakegame_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cakegame_top (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire cakegame_bus_pkg::wb_req_t wb_req,
    output cakegame_bus_pkg::wb_rsp_t      wb_rsp,
    input  wire cakegame_pkg::play_t       buttons,
    output cakegame_pkg::play_t            leds,
    output logic                           finished
);

    cakegame_pkg::cfg_t       cfg;
    cakegame_pkg::mem_wr_t    mem_wr;
    cakegame_pkg::ctl_t       ctl;
    cakegame_pkg::dp_status_t status;
    cakegame_pkg::ctl_state_t state;
    cakegame_pkg::points_t    points;
    logic                     start;

    cakegame_regs regs0 (
        .clock    (clock),
        .reset    (reset),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .cfg      (cfg),
        .mem_wr   (mem_wr),
        .start    (start),
        .state    (state),
        .finished (finished),
        .points   (points)
    );

    cakegame_uc uc0 (
        .clock    (clock),
        .reset    (reset),
        .start    (start),
        .status   (status),
        .ctl      (ctl),
        .finished (finished),
        .state    (state)
    );

    cakegame_datapath dp0 (
        .clock   (clock),
        .reset   (reset),
        .ctl     (ctl),
        .cfg     (cfg),
        .mem_wr  (mem_wr),
        .buttons (buttons),
        .status  (status),
        .points  (points),
        .leds    (leds)
    );

endmodule

`default_nettype wire

/* test/cakegame_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module cakegame_assertions (
    input wire logic                      clock,
    input wire logic                      reset,
    input wire cakegame_bus_pkg::wb_req_t wb_req,
    input wire cakegame_bus_pkg::wb_rsp_t wb_rsp,
    input wire cakegame_pkg::play_t       leds,
    input wire logic                      finished,
    input wire cakegame_pkg::ctl_t        ctl,
    input wire cakegame_pkg::ctl_state_t  state
);

    int fail_count = 0;

    ack_needs_request: assert property (@(posedge clock) disable iff (reset)
        $rose(wb_rsp.ack) |-> $past(wb_req.cyc && wb_req.stb))
        else begin
            $error("ack rose without cyc and stb");
            fail_count++;
        end

    ack_single_cycle: assert property (@(posedge clock) disable iff (reset)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            $error("ack held longer than one cycle");
            fail_count++;
        end

    outputs_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> (leds == '0) && !finished)
        else begin
            $error("leds or finished active after reset");
            fail_count++;
        end

    enable_reg_state: assert property (@(posedge clock) disable iff (reset)
        ctl.enable_reg |-> state == cakegame_pkg::register_play)
        else begin
            $error("enable_reg outside register_play");
            fail_count++;
        end

endmodule

bind cakegame_top cakegame_assertions asrt0 (
    .clock    (clock),
    .reset    (reset),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .leds     (leds),
    .finished (finished),
    .ctl      (ctl),
    .state    (state)
);

`default_nettype wire

/* test/cakegame_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cakegame_config.svh"

module cakegame_tb;

    localparam int CYCLES_PER_RECORD = 300;
    localparam int MAX_RECORDS       = 64;

    logic                      clock;
    logic                      reset;
    cakegame_bus_pkg::wb_req_t wb_req;
    cakegame_bus_pkg::wb_rsp_t wb_rsp;
    cakegame_pkg::play_t       buttons;
    cakegame_pkg::play_t       leds;
    logic                      finished;

    logic [63:0] stim [MAX_RECORDS];
    int          n_records;
    int          cycles;
    int          cycle_limit;
    int          show_cycles;   // tracks the SHOW register
    int          game_len;      // tracks the LEN register
    int          press_count;   // presses since the last start
    int          dat_errors;
    int          play_errors;
    int          points_errors;
    int          flag_errors;
    int          other_errors;

    cakegame_top dut0 (
        .clock    (clock),
        .reset    (reset),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .buttons  (buttons),
        .leds     (leds),
        .finished (finished)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) cycles <= cycles + 1;

    task automatic tick();
        @(posedge clock);
        #2;
    endtask

    task automatic check_dat(input string name, input cakegame_bus_pkg::wb_dat_t exp,
                             input cakegame_bus_pkg::wb_dat_t act);
        if (act !== exp) begin
            dat_errors++;
            $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    task automatic check_play(input string name, input cakegame_pkg::play_t exp,
                              input cakegame_pkg::play_t act);
        if (act !== exp) begin
            play_errors++;
            $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    task automatic check_points(input string name, input cakegame_pkg::points_t exp,
                                input cakegame_pkg::points_t act);
        if (act !== exp) begin
            points_errors++;
            $display("MISMATCH time=%0t %s expected=%0d actual=%0d", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            flag_errors++;
            $display("MISMATCH time=%0t %s expected=%b actual=%b", $time, name, exp, act);
        end
    endtask

    // classic cycle, request held until ack
    task automatic bus_access(input logic we, input cakegame_bus_pkg::wb_adr_t adr,
                              input cakegame_bus_pkg::wb_dat_t dat_w,
                              output cakegame_bus_pkg::wb_dat_t dat_r);
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.adr   = adr;
        wb_req.dat_w = dat_w;
        tick();
        while (wb_rsp.ack !== 1'b1) tick();
        dat_r  = wb_rsp.dat_r;
        wb_req = '0;
        if (we && adr == `CAKE_REG_SHOW) show_cycles = dat_w;
        if (we && adr == `CAKE_REG_LEN) game_len = dat_w[4:0];
        if (we && adr == `CAKE_REG_CTRL && dat_w[0]) press_count = 0;
    endtask

    task automatic load_sequence(input int n, input logic [31:0] plays);
        cakegame_bus_pkg::wb_dat_t rd;
        bus_access(1'b1, `CAKE_REG_LEN, cakegame_bus_pkg::wb_dat_t'(n), rd);
        for (int i = 0; i < n; i++) begin
            bus_access(1'b1, cakegame_bus_pkg::wb_adr_t'(`CAKE_REG_MEM_BASE + i),
                       cakegame_bus_pkg::wb_dat_t'(plays[31-4*i -: 4]), rd);
        end
    endtask

    // each play shows up as a zero to nonzero step on leds
    task automatic check_show(input int n, input logic [31:0] plays);
        cakegame_pkg::play_t prev;
        int                  seen;
        prev = leds;
        seen = 0;
        while (seen < n) begin
            tick();
            if (leds != '0 && prev == '0) begin
                check_play($sformatf("leds show %0d", seen), plays[31-4*seen -: 4], leds);
                seen++;
            end
            prev = leds;
        end
    endtask

    // the game ends one cycle after the echo once the last play is pressed
    task automatic press(input cakegame_pkg::play_t value, input int hold);
        int gap;
        int last;
        gap  = show_cycles + int'($urandom % 4);   // past the end of the show phase
        last = (hold > 5) ? hold : 5;
        press_count++;
        repeat (gap) tick();
        buttons = value;
        for (int c = 1; c <= last; c++) begin
            tick();
            if (c == hold) buttons = '0;
            if (c == 4) check_play("leds echo", value, leds);
            if (c == 5) check_flag("finished", press_count == game_len, finished);
        end
        buttons = '0;
    endtask

    task automatic wait_finished(input cakegame_pkg::points_t exp_points);
        cakegame_bus_pkg::wb_dat_t status;
        while (finished !== 1'b1) tick();
        bus_access(1'b0, `CAKE_REG_STATUS, '0, status);
        check_points("points", exp_points, cakegame_pkg::points_t'(status[4:0]));
    endtask

    task automatic run_record(input logic [63:0] rec);
        cakegame_bus_pkg::wb_adr_t adr;
        cakegame_bus_pkg::wb_dat_t rd;
        logic [3:0]                op;
        int                        n;
        int                        hold;
        logic [31:0]               data;
        op   = rec[63:60];
        n    = rec[59:56];
        hold = rec[55:48];
        adr  = rec[44:40];
        data = rec[31:0];
        case (op)
            4'd1: bus_access(1'b1, adr, data[15:0], rd);
            4'd2: begin
                bus_access(1'b0, adr, '0, rd);
                check_dat($sformatf("dat_r at address %0d", adr), data[15:0], rd);
            end
            4'd3: load_sequence(n, data);
            4'd4: check_show(n, data);
            4'd5: press(data[3:0], hold);
            4'd6: wait_finished(data[4:0]);
            default: begin
                other_errors++;
                $display("stim record %h has an unknown operation", rec);
            end
        endcase
    endtask

    initial begin : watchdog
        wait (cycle_limit > 0);
        wait (cycles >= cycle_limit);
        $display("run stopped after %0d cycles, the DUT did not finish the stim file", cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : main
        int total;
        cycles        = 0;
        cycle_limit   = 0;
        show_cycles   = 8;
        game_len      = 4;
        press_count   = 0;
        dat_errors    = 0;
        play_errors   = 0;
        points_errors = 0;
        flag_errors   = 0;
        other_errors  = 0;
        reset         = 1'b1;
        wb_req        = '0;
        buttons       = '0;
        void'($urandom(32'h917bee00));
        for (int i = 0; i < MAX_RECORDS; i++) stim[i] = '0;
        $readmemh("test/cakegame_stim.txt", stim);
        n_records = 0;
        while (n_records < MAX_RECORDS && stim[n_records][63:60] != 4'd0) n_records++;
        if (n_records == 0) begin
            other_errors++;
            $display("stim file test/cakegame_stim.txt holds no records");
        end
        cycle_limit = (n_records + 1) * CYCLES_PER_RECORD;
        repeat (4) @(posedge clock);
        #2;
        reset = 1'b0;
        for (int i = 0; i < n_records; i++) run_record(stim[i]);
        tick();
        tick();
        total = dat_errors + play_errors + points_errors + flag_errors + other_errors
              + dut0.asrt0.fail_count;
        $display("errors: dat=%0d play=%0d points=%0d flag=%0d other=%0d assertions=%0d",
                 dat_errors, play_errors, points_errors, flag_errors, other_errors,
                 dut0.asrt0.fail_count);
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/cakegame_stim.txt */
// op n hold adr pad data: 1 write, 2 read and compare, 3 load n plays, 4 show check of n plays
// 5 press data[3:0] for hold cycles, 6 wait for finished and compare points; plays left aligned
2_0_00_04_00_00000000
1_0_00_01_00_00000005
1_0_00_02_00_0000000A
1_0_00_03_00_0000003C
2_0_00_01_00_00000005
2_0_00_02_00_0000000A
2_0_00_03_00_0000003C
3_5_00_00_00_12482000
1_0_00_00_00_00000001
4_5_00_00_00_12482000
5_0_02_00_00_00000001
5_0_03_00_00_00000002
5_0_01_00_00_00000004
5_0_06_00_00_00000008
5_0_02_00_00_00000002
6_0_00_00_00_00000005
3_4_00_00_00_84210000
1_0_00_00_00_00000001
4_4_00_00_00_84210000
5_0_02_00_00_00000008
5_0_01_00_00_00000002
5_0_03_00_00_00000002
5_0_05_00_00_00000004
6_0_00_00_00_00000002
3_4_00_00_00_22140000
1_0_00_00_00_00000001
4_4_00_00_00_22140000
5_0_02_00_00_00000002
5_0_02_00_00_00000001
6_0_00_00_00_00000001
2_0_00_04_00_00008F01
3_3_00_00_00_41800000
1_0_00_00_00_00000001
4_3_00_00_00_41800000
5_0_02_00_00_00000004
5_0_04_00_00_00000001
5_0_01_00_00_00000008
6_0_00_00_00_00000003
2_0_00_04_00_00008F03

/* all.f */
+incdir+common
common/cakegame_pkg.sv
common/cakegame_bus_pkg.sv
rtl/cakegame_uc.sv
rtl/cakegame_regs.sv
datapath/cakegame_datapath.sv
rtl/cakegame_top.sv
test/cakegame_assertions.sv
test/cakegame_tb.sv
